// File: verilog/geiger_pkg.sv
package geiger_pkg;

    // ------------------------------------------------------------
    // counter and display widths

    // six hex digits of particle count
    localparam int w_particle_cnt   = 24;
    localparam int w_hex_digit      = 4;
    localparam int n_display_digits = 8;

    // whatever digits are left over show the active time
    localparam int w_time_cnt = n_display_digits * w_hex_digit - w_particle_cnt;

    // ------------------------------------------------------------
    // hex glyphs, active high, bit 6 is segment a

    function automatic logic [6:0] hex_to_segments (input logic [3:0] hex);
        logic [6:0] seg;
        case (hex)
        4'h0:    seg = 7'b1111110;
        4'h1:    seg = 7'b0110000;
        4'h2:    seg = 7'b1101101;
        4'h3:    seg = 7'b1111001;
        4'h4:    seg = 7'b0110011;
        4'h5:    seg = 7'b1011011;
        4'h6:    seg = 7'b1011111;
        4'h7:    seg = 7'b1110000;
        4'h8:    seg = 7'b1111111;
        4'h9:    seg = 7'b1111011;
        4'ha:    seg = 7'b1110111;
        4'hb:    seg = 7'b0011111;
        4'hc:    seg = 7'b1001110;
        4'hd:    seg = 7'b0111101;
        4'he:    seg = 7'b1001111;
        default: seg = 7'b1000111;
        endcase
        return seg;
    endfunction

endpackage

// File: verilog/geiger_sync.sv
`timescale 1ns/1ps

module geiger_sync
#(
    parameter n_tubes      = 2,
    parameter deglitch_len = 4
)
(
    input                  clk,
    input                  rst,
    input  [n_tubes - 1:0] detector,
    output [n_tubes - 1:0] line_clean
);

    localparam w_run = $clog2 (deglitch_len + 1);

    // ------------------------------------------------------------
    // two-flop synchronizer

    logic [n_tubes - 1:0] sync_1;
    logic [n_tubes - 1:0] sync_2;

    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            sync_1 <= '0;
            sync_2 <= '0;
        end
        else
        begin
            sync_1 <= detector;
            sync_2 <= sync_1;
        end

    // ------------------------------------------------------------
    // run-length deglitch, one counter per line

    genvar i;

    generate
        for (i = 0; i < n_tubes; i ++)
        begin : lane
            logic [w_run - 1:0] run_cnt;
            logic               clean_r;

            // count samples that disagree with the accepted level
            always_ff @ (posedge clk or posedge rst)
                if (rst)
                begin
                    run_cnt <= '0;
                    clean_r <= 1'b0;
                end
                else if (sync_2 [i] == clean_r)
                    run_cnt <= '0;
                else if (run_cnt == w_run' (deglitch_len - 1))
                begin
                    run_cnt <= '0;
                    clean_r <= sync_2 [i];
                end
                else
                    run_cnt <= run_cnt + 1'd1;

            assign line_clean [i] = clean_r;

            run_cnt_in_range : assert property (
                @ (posedge clk) disable iff (rst)
                run_cnt <= w_run' (deglitch_len)
            );
        end
    endgenerate

endmodule

// File: verilog/geiger_channel.sv
`timescale 1ns/1ps

module geiger_channel
#(
    parameter ext_cycles = 10_000_000
)
(
    input        clk,
    input        rst,
    input        line_clean,
    output logic hit,
    output       pulse_ext
);

    localparam w_ext_cnt = $clog2 (ext_cycles + 1);

    // ------------------------------------------------------------
    // rising edge

    logic line_prev;

    wire rise = line_clean & ~ line_prev;

    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            line_prev <= 1'b0;
            hit       <= 1'b0;
        end
        else
        begin
            line_prev <= line_clean;
            hit       <= rise;
        end

    // ------------------------------------------------------------
    // pulse extension

    // loaded on the same edge that sets hit,
    // so the stretched pulse starts together with it
    logic [w_ext_cnt - 1:0] ext_cnt;

    always_ff @ (posedge clk or posedge rst)
        if (rst)
            ext_cnt <= '0;
        else if (rise)
            ext_cnt <= w_ext_cnt' (ext_cycles);
        else if (ext_cnt != '0)
            ext_cnt <= ext_cnt - 1'd1;

    assign pulse_ext = | ext_cnt;

    // ------------------------------------------------------------
    // checks

    hit_single_cycle : assert property (
        @ (posedge clk) disable iff (rst)
        hit |=> ! hit
    );

    ext_cnt_in_range : assert property (
        @ (posedge clk) disable iff (rst)
        ext_cnt <= w_ext_cnt' (ext_cycles)
    );

endmodule

// File: verilog/particle_tally.sv
`timescale 1ns/1ps

module particle_tally
    import geiger_pkg::*;
#(
    parameter n_tubes = 2
)
(
    input                               clk,
    input                               rst,
    input        [n_tubes        - 1:0] hit,
    input        [n_tubes        - 1:0] line_clean,
    output logic [w_particle_cnt - 1:0] particle_cnt,
    output logic [w_time_cnt     - 1:0] time_cnt
);

    // wide enough to hold n_tubes itself
    localparam w_sum = $clog2 (n_tubes + 1);

    // ------------------------------------------------------------
    // population counts

    logic [w_sum - 1:0] num_hit;
    logic [w_sum - 1:0] num_active;

    always_comb
    begin
        num_hit = '0;

        for (int i = 0; i < n_tubes; i ++)
            num_hit += w_sum' (hit [i]);
    end

    always_comb
    begin
        num_active = '0;

        for (int i = 0; i < n_tubes; i ++)
            num_active += w_sum' (line_clean [i]);
    end

    // ------------------------------------------------------------
    // particle counter

    // one count per edge, several tubes may fire on the same cycle
    always_ff @ (posedge clk or posedge rst)
        if (rst)
            particle_cnt <= '0;
        else
            particle_cnt <= particle_cnt + w_particle_cnt' (num_hit);

    // ------------------------------------------------------------
    // active time counter

    // advances by the number of lines high this cycle, wraps freely
    always_ff @ (posedge clk or posedge rst)
        if (rst)
            time_cnt <= '0;
        else
            time_cnt <= time_cnt + w_time_cnt' (num_active);

endmodule

// File: verilog/seven_segment_display.sv
`timescale 1ns/1ps

module seven_segment_display
    import geiger_pkg::*;
#(
    parameter scan_cycles = 50_000
)
(
    input                                               clk,
    input                                               rst,
    input        [n_display_digits * w_hex_digit - 1:0] number,
    input        [n_display_digits               - 1:0] dots,
    output logic [                                 7:0] abcdefgh,
    output logic [n_display_digits               - 1:0] digit
);

    localparam w_scan  = scan_cycles > 1 ? $clog2 (scan_cycles) : 1;
    localparam w_index = $clog2 (n_display_digits);

    // counters are all zero after reset, so digit 0 starts out showing 0
    localparam logic [6:0] seg_zero = hex_to_segments (4'h0);

    // ------------------------------------------------------------
    // prescaler

    logic [w_scan - 1:0] scan_cnt;

    wire slot_end = (scan_cnt == w_scan' (scan_cycles - 1));

    always_ff @ (posedge clk or posedge rst)
        if (rst)
            scan_cnt <= '0;
        else if (slot_end)
            scan_cnt <= '0;
        else
            scan_cnt <= scan_cnt + 1'd1;

    // ------------------------------------------------------------
    // digit index

    logic [w_index - 1:0] index;
    logic [w_index - 1:0] index_next;

    always_comb
        if (index == w_index' (n_display_digits - 1))
            index_next = '0;
        else
            index_next = index + 1'd1;

    always_ff @ (posedge clk or posedge rst)
        if (rst)
            index <= '0;
        else if (slot_end)
            index <= index_next;

    // ------------------------------------------------------------
    // registered segment and digit outputs

    logic [w_hex_digit - 1:0] nibble;

    // the upcoming digit's value, latched as its slot begins
    assign nibble = number [index_next * w_hex_digit +: w_hex_digit];

    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            digit    <= n_display_digits' (1);
            abcdefgh <= { seg_zero, 1'b0 };
        end
        else if (slot_end)
        begin
            digit    <= n_display_digits' (1) << index_next;
            abcdefgh <= { hex_to_segments (nibble), dots [index_next] };
        end

    // ------------------------------------------------------------
    // checks

    digit_one_hot : assert property (
        @ (posedge clk) disable iff (rst)
        $onehot (digit)
    );

endmodule

// File: verilog/geiger_counter_top.sv
`timescale 1ns/1ps

module geiger_counter_top
    import geiger_pkg::*;
#(
    parameter clk_mhz      = 50,
              n_tubes      = 2,

              // 0.2 s of visible pulse per hit
              ext_cycles   = clk_mhz * 200_000,

              // 1 ms per digit
              scan_cycles  = clk_mhz * 1_000,

              // 1 us of stable level
              deglitch_len = clk_mhz,

              w_led        = 8
)
(
    input                           clk,
    input                           rst,
    input  [n_tubes          - 1:0] detector,
    output [w_led            - 1:0] led,
    output [                   7:0] abcdefgh,
    output [n_display_digits - 1:0] digit,
    output                          speaker
);

    // enough copies of the pulse vector to cover the target width
    localparam n_led_rep = (w_led            + n_tubes - 1) / n_tubes,
               n_dot_rep = (n_display_digits + n_tubes - 1) / n_tubes;

    wire [n_tubes        - 1:0] line_clean;
    wire [n_tubes        - 1:0] hit;
    wire [n_tubes        - 1:0] pulse_ext;
    wire [w_particle_cnt - 1:0] particle_cnt;
    wire [w_time_cnt     - 1:0] time_cnt;

    // ------------------------------------------------------------
    // front end

    geiger_sync
    # (
        .n_tubes      ( n_tubes      ),
        .deglitch_len ( deglitch_len )
    )
    i_sync
    (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .detector   ( detector   ),
        .line_clean ( line_clean )
    );

    // ------------------------------------------------------------
    // per-tube channels

    genvar i;

    generate
        for (i = 0; i < n_tubes; i ++)
        begin : tube
            geiger_channel # (.ext_cycles (ext_cycles)) i_channel
            (
                .clk        ( clk            ),
                .rst        ( rst            ),
                .line_clean ( line_clean [i] ),
                .hit        ( hit        [i] ),
                .pulse_ext  ( pulse_ext  [i] )
            );
        end
    endgenerate

    // ------------------------------------------------------------
    // counters

    particle_tally # (.n_tubes (n_tubes)) i_tally
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .hit          ( hit          ),
        .line_clean   ( line_clean   ),
        .particle_cnt ( particle_cnt ),
        .time_cnt     ( time_cnt     )
    );

    // ------------------------------------------------------------
    // display, time in the top digits

    seven_segment_display # (.scan_cycles (scan_cycles)) i_display
    (
        .clk      ( clk                                                ),
        .rst      ( rst                                                ),
        .number   ( { time_cnt, particle_cnt }                         ),
        .dots     ( n_display_digits' ({ n_dot_rep { pulse_ext } })    ),
        .abcdefgh ( abcdefgh                                           ),
        .digit    ( digit                                              )
    );

    // ------------------------------------------------------------
    // leds and speaker

    assign led     = w_led' ({ n_led_rep { pulse_ext } });
    assign speaker = | pulse_ext;

endmodule

// File: bench/tb_geiger_counter.sv
`timescale 1ns/1ps

module tb_geiger_counter
    import geiger_pkg::*;
();

    localparam int n_tubes      = 2;
    localparam int ext_cycles   = 40;
    localparam int scan_cycles  = 4;
    localparam int deglitch_len = 2;
    localparam int w_led        = 8;

    localparam int n_phases       = 6;
    localparam int active_cycles  = 300;
    localparam int quiet_cycles   = 20;
    localparam int sweep_cycles   = scan_cycles * n_display_digits;
    localparam int phase_cycles   = active_cycles + quiet_cycles + 3 * sweep_cycles;
    localparam int reset_cycles   = 2 + 3 * sweep_cycles;
    localparam int timeout_cycles = 3 * (reset_cycles + n_phases * phase_cycles);

    // slack between an accepted pulse and its led edges
    localparam int led_slack  = 5;
    localparam int timer_idle = 1000;

    localparam int st_gap    = 0;
    localparam int st_pulse  = 1;
    localparam int st_glitch = 2;

    logic                          clk;
    logic                          rst;
    logic [n_tubes          - 1:0] detector;
    wire  [w_led            - 1:0] led;
    wire  [                   7:0] abcdefgh;
    wire  [n_display_digits - 1:0] digit;
    wire                           speaker;

    geiger_counter_top
    # (
        .clk_mhz      ( 1            ),
        .n_tubes      ( n_tubes      ),
        .ext_cycles   ( ext_cycles   ),
        .scan_cycles  ( scan_cycles  ),
        .deglitch_len ( deglitch_len ),
        .w_led        ( w_led        )
    )
    geiger_counter_top_i
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .detector ( detector ),
        .led      ( led      ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    ),
        .speaker  ( speaker  )
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~ clk;
    end

    // ------------------------------------------------------------
    // state of the reference model and the display decoder

    integer seed = 32'he33bf7a5;

    int gen_state  [n_tubes];
    int gen_remain [n_tubes];

    logic [n_tubes - 1:0] flt_level;
    logic [n_tubes - 1:0] raw_prev;
    int                   flt_run       [n_tubes];
    int                   stretch_timer [n_tubes];
    int                   model_particles;
    int                   model_active;

    logic [3:0]                    shown [n_display_digits];
    logic [n_display_digits - 1:0] prev_digit;
    int                            sweep_cnt;
    int                            cycle_cnt;
    int                            err_value;
    int                            err_other;

    function automatic int rand_range (input int lo, input int hi);
        logic [31:0] r;
        r = $random (seed);
        return lo + int' (r % (hi - lo + 1));
    endfunction

    // inverse glyph lookup, -1 for a pattern that is no hex digit
    function automatic int decode_segments (input logic [6:0] seg);
        int value;
        int h;
        value = -1;
        for (h = 0; h < 16; h ++)
            if (hex_to_segments (4' (h)) == seg)
                value = h;
        return value;
    endfunction

    // ------------------------------------------------------------
    // stimulus

    // gap, then either a glitch or a pulse, always back to a gap
    task automatic next_level (input int t, output logic level);
        if (gen_remain [t] == 0)
        begin
            if (gen_state [t] == st_gap && rand_range (0, 3) == 0)
            begin
                gen_state  [t] = st_glitch;
                gen_remain [t] = 1;
            end
            else if (gen_state [t] == st_gap)
            begin
                gen_state  [t] = st_pulse;
                gen_remain [t] = rand_range (3, 10);
            end
            else
            begin
                gen_state  [t] = st_gap;
                gen_remain [t] = rand_range (3, 10);
            end
        end
        level = (gen_state [t] != st_gap);
        gen_remain [t] --;
    endtask

    task automatic start_generators ();
        for (int t = 0; t < n_tubes; t ++)
        begin
            gen_state  [t] = st_gap;
            gen_remain [t] = rand_range (3, 10);
        end
    endtask

    task automatic drive_cycle ();
        logic [n_tubes - 1:0] levels;
        logic                 level;
        for (int t = 0; t < n_tubes; t ++)
        begin
            next_level (t, level);
            levels [t] = level;
        end
        @ (posedge clk);
        detector <= levels;
    endtask

    task automatic wait_sweeps (input int n);
        int target;
        @ (posedge clk);
        target = sweep_cnt + n;
        while (sweep_cnt < target)
            @ (posedge clk);
    endtask

    // ------------------------------------------------------------
    // checks

    task automatic check_after_reset ();
        if (digit !== n_display_digits' (1))
        begin
            $display ("[FAIL] digit = %h, expected %h", digit, n_display_digits' (1));
            err_value ++;
        end
        if (led !== '0)
        begin
            $display ("[FAIL] led = %h, expected %h", led, w_led' (0));
            err_value ++;
        end
        if (speaker !== 1'b0)
        begin
            $display ("[FAIL] speaker = %h, expected 0", speaker);
            err_value ++;
        end
    endtask

    task automatic check_display (input string tag);
        logic [n_display_digits * w_hex_digit - 1:0] shown_number;
        logic [w_particle_cnt - 1:0]                 exp_particles;
        logic [w_time_cnt     - 1:0]                 exp_time;
        for (int i = 0; i < n_display_digits; i ++)
            shown_number [i * w_hex_digit +: w_hex_digit] = shown [i];
        exp_particles = w_particle_cnt' (model_particles);
        exp_time      = w_time_cnt'     (model_active);
        if (shown_number [w_particle_cnt - 1:0] !== exp_particles)
        begin
            $display ("[FAIL] %s: particle_cnt shown %h, expected %h",
                tag, shown_number [w_particle_cnt - 1:0], exp_particles);
            err_value ++;
        end
        if (shown_number [$high (shown_number):w_particle_cnt] !== exp_time)
        begin
            $display ("[FAIL] %s: time_cnt shown %h, expected %h",
                tag, shown_number [$high (shown_number):w_particle_cnt], exp_time);
            err_value ++;
        end
    endtask

    // ------------------------------------------------------------
    // model and monitor, all on the falling edge

    always @ (negedge clk)
    begin : monitor
        int   t;
        int   b;
        int   idx;
        int   ones;
        int   value;
        logic rose;
        cycle_cnt ++;
        if (cycle_cnt >= timeout_cycles)
        begin
            $display ("timeout, the run did not finish within %0d cycles", timeout_cycles);
            $display ("errors: %0d wrong values, %0d other", err_value, err_other);
            $display ("Result: FAILED");
            $finish;
        end
        else if (rst !== 1'b0)
        begin
            flt_level       = '0;
            raw_prev        = '0;
            model_particles = 0;
            model_active    = 0;
            sweep_cnt       = 0;
            for (t = 0; t < n_tubes; t ++)
            begin
                flt_run       [t] = 0;
                stretch_timer [t] = timer_idle;
            end
            prev_digit = digit;
        end
        else
        begin
            // display decoder, one lit digit per cycle
            ones = 0;
            idx  = 0;
            for (b = 0; b < n_display_digits; b ++)
                if (digit [b] === 1'b1)
                begin
                    ones ++;
                    idx = b;
                end
            if (ones != 1)
            begin
                $display ("digit select %b does not light exactly one digit", digit);
                err_other ++;
            end
            else
            begin
                value = decode_segments (abcdefgh [7:1]);
                if (value < 0)
                begin
                    $display ("segments %b on digit %0d show no hex digit",
                        abcdefgh [7:1], idx);
                    err_other ++;
                end
                else
                    shown [idx] = 4' (value);

                // dot was latched one cycle before its slot began
                if (digit !== prev_digit)
                begin
                    t = idx % n_tubes;
                    if (stretch_timer [t] >= led_slack && stretch_timer [t] < ext_cycles
                        && abcdefgh [0] !== 1'b1)
                    begin
                        $display ("[FAIL] abcdefgh[0] on digit %0d = %h, expected 1",
                            idx, abcdefgh [0]);
                        err_value ++;
                    end
                    if (stretch_timer [t] >= ext_cycles + led_slack && abcdefgh [0] !== 1'b0)
                    begin
                        $display ("[FAIL] abcdefgh[0] on digit %0d = %h, expected 0",
                            idx, abcdefgh [0]);
                        err_value ++;
                    end
                    if (idx == 0)
                        sweep_cnt ++;
                end
            end
            prev_digit = digit;

            // a level counts once it has been seen deglitch_len times in a row
            for (t = 0; t < n_tubes; t ++)
            begin
                if (detector [t] === raw_prev [t])
                    flt_run [t] ++;
                else
                    flt_run [t] = 1;
                raw_prev [t] = detector [t];

                rose = 1'b0;
                if (flt_run [t] >= deglitch_len && flt_level [t] !== detector [t])
                begin
                    rose          = detector [t];
                    flt_level [t] = detector [t];
                end

                if (stretch_timer [t] < timer_idle)
                    stretch_timer [t] ++;
                if (rose)
                begin
                    model_particles ++;
                    stretch_timer [t] = 0;
                end
                if (flt_level [t])
                    model_active ++;
            end

            // each led bit mirrors tube b modulo n_tubes
            for (b = 0; b < w_led; b ++)
            begin
                t = b % n_tubes;
                if (stretch_timer [t] >= led_slack && stretch_timer [t] < ext_cycles
                    && led [b] !== 1'b1)
                begin
                    $display ("[FAIL] led[%0d] = %h, expected 1", b, led [b]);
                    err_value ++;
                end
                if (stretch_timer [t] >= ext_cycles + led_slack && led [b] !== 1'b0)
                begin
                    $display ("[FAIL] led[%0d] = %h, expected 0", b, led [b]);
                    err_value ++;
                end
            end
            if (speaker !== (| led))
            begin
                $display ("[FAIL] speaker = %h, expected %h", speaker, | led);
                err_value ++;
            end
        end
    end

    initial
    begin : main
        int phase;
        rst       = 1'b1;
        detector  = '0;
        err_value = 0;
        err_other = 0;
        cycle_cnt = 0;
        repeat (2) @ (posedge clk);
        rst <= 1'b0;
        @ (negedge clk);
        check_after_reset ();
        wait_sweeps (2);
        check_display ("after reset");
        for (phase = 0; phase < n_phases; phase ++)
        begin
            start_generators ();
            repeat (active_cycles)
                drive_cycle ();
            @ (posedge clk);
            detector <= '0;
            repeat (quiet_cycles) @ (posedge clk);
            wait_sweeps (2);
            check_display ($sformatf ("phase %0d", phase));
        end
        $display ("errors: %0d wrong values, %0d other", err_value, err_other);
        if (err_value + err_other == 0)
            $display ("Result: PASSED");
        else
            $display ("Result: FAILED");
        $finish;
    end

endmodule

// File: flist.f
verilog/geiger_pkg.sv
verilog/geiger_sync.sv
verilog/geiger_channel.sv
verilog/particle_tally.sv
verilog/seven_segment_display.sv
verilog/geiger_counter_top.sv
bench/tb_geiger_counter.sv

// File: Bender.yml
package:
  name: geiger_counter

sources:
  - files:
      - verilog/geiger_pkg.sv
      - verilog/geiger_sync.sv
      - verilog/geiger_channel.sv
      - verilog/particle_tally.sv
      - verilog/seven_segment_display.sv
      - verilog/geiger_counter_top.sv
  - target: test
    files:
      - bench/tb_geiger_counter.sv
